/* logic/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // --------------------------------------------------------------------------
  // bus and memory geometry.
  // --------------------------------------------------------------------------
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;

  localparam int mem_words = 1024;
  localparam int word_index_width = $clog2(mem_words);

  // the window starts here and covers mem_words whole words.
  localparam logic [data_width-1:0] mem_base = 32'h8000_0000;
  localparam logic [data_width-1:0] mem_limit =
      mem_base + data_width'(mem_words * strb_width);

  // response codes carried on rresp and bresp.
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_decerr = 2'b11
  } resp_t;

  // --------------------------------------------------------------------------
  // address helpers.
  // --------------------------------------------------------------------------
  function automatic logic in_window(input logic [data_width-1:0] addr);
    return (addr >= mem_base) && (addr < mem_limit);
  endfunction

  // the low two bits select a lane and are dropped here.
  function automatic logic [word_index_width-1:0] word_index(
      input logic [data_width-1:0] addr);
    logic [data_width-1:0] offset;
    offset = addr - mem_base;
    return offset[word_index_width+1:2];
  endfunction

endpackage

`default_nettype wire

/* logic/mem_bus_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if;
  import mem_pkg::*;

  // read address and read data.
  logic [data_width-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [data_width-1:0] rdata;
  resp_t                 rresp;
  logic                  rvalid;
  logic                  rready;

  // write address, write data and write response.
  logic [data_width-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [data_width-1:0] wdata;
  logic [strb_width-1:0] wstrb;
  logic                  wvalid;
  logic                  wready;
  resp_t                 bresp;
  logic                  bvalid;
  logic                  bready;

  modport manager (
    output araddr, arvalid, input arready,
    input rdata, rresp, rvalid, output rready,
    output awaddr, awvalid, input awready,
    output wdata, wstrb, wvalid, input wready,
    input bresp, bvalid, output bready
  );

  // the read and write responders share this view and each drives its own side.
  modport subordinate (
    input araddr, arvalid, output arready,
    output rdata, rresp, rvalid, input rready,
    input awaddr, awvalid, output awready,
    input wdata, wstrb, wvalid, output wready,
    output bresp, bvalid, input bready
  );

endinterface

`default_nettype wire

/* logic/data_store.sv */
`timescale 1ns/100ps
`default_nettype none

module data_store (
  input  wire                                  clock,
  input  wire                                  read_en,
  input  wire  [mem_pkg::word_index_width-1:0] read_index,
  input  wire                                  write_en,
  input  wire  [mem_pkg::word_index_width-1:0] write_index,
  input  wire  [mem_pkg::data_width-1:0]       write_data,
  input  wire  [mem_pkg::strb_width-1:0]       write_strb,
  output logic [mem_pkg::data_width-1:0]       read_data
);
  import mem_pkg::*;

  logic [data_width-1:0] words [mem_words];

  // byte lanes are written independently under their strobes.
  always_ff @(posedge clock) begin
    if (write_en) begin
      for (int lane = 0; lane < strb_width; lane++) begin
        if (write_strb[lane]) begin
          words[write_index][lane*8 +: 8] <= write_data[lane*8 +: 8];
        end
      end
    end
  end

  // one cycle read latency; the word holds until the next read.
  always_ff @(posedge clock) begin
    if (read_en) begin
      read_data <= words[read_index];
    end
  end

endmodule

`default_nettype wire

/* logic/mem_read_responder.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_read_responder (
  input  wire                                  clock,
  input  wire                                  reset,
  mem_bus_if.subordinate                       bus,
  output logic                                 store_read_en,
  output logic [mem_pkg::word_index_width-1:0] store_read_index,
  input  wire  [mem_pkg::data_width-1:0]       store_read_data
);
  import mem_pkg::*;

  logic addr_transfer;
  logic addr_hit;
  logic read_hit;

  assign addr_transfer = bus.arvalid && bus.arready;
  assign addr_hit = in_window(bus.araddr);

  // the store is only touched for addresses inside the window.
  assign store_read_en = addr_transfer && addr_hit;
  assign store_read_index = word_index(bus.araddr);

  always_ff @(posedge clock) begin
    if (reset) begin
      bus.arready <= 1'b0;
      bus.rvalid  <= 1'b0;
    end else begin
      if (addr_transfer) begin
        bus.arready <= 1'b0;
        bus.rvalid  <= 1'b1;
      end else if (bus.arvalid && !bus.rvalid) begin
        bus.arready <= 1'b1;
      end
      if (bus.rvalid && bus.rready) begin
        bus.rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (addr_transfer) begin
      read_hit  <= addr_hit;
      bus.rresp <= addr_hit ? resp_okay : resp_decerr;
    end
  end

  // store_read_data holds until the next read enable, so rdata is stable under rvalid.
  assign bus.rdata = read_hit ? store_read_data : '0;

endmodule

`default_nettype wire

/* logic/mem_write_responder.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_write_responder (
  input  wire                                  clock,
  input  wire                                  reset,
  mem_bus_if.subordinate                       bus,
  output logic                                 store_write_en,
  output logic [mem_pkg::word_index_width-1:0] store_write_index,
  output logic [mem_pkg::data_width-1:0]       store_write_data,
  output logic [mem_pkg::strb_width-1:0]       store_write_strb
);
  import mem_pkg::*;

  logic                  aw_held;
  logic                  w_held;
  logic [data_width-1:0] aw_addr;
  logic [data_width-1:0] w_data;
  logic [strb_width-1:0] w_strb;
  logic                  write_now;

  // address and data may arrive in either order; both are held until paired.
  assign write_now = aw_held && w_held;

  assign store_write_en    = write_now && in_window(aw_addr);
  assign store_write_index = word_index(aw_addr);
  assign store_write_data  = w_data;
  assign store_write_strb  = w_strb;

  always_ff @(posedge clock) begin
    if (reset) begin
      bus.awready <= 1'b0;
      bus.wready  <= 1'b0;
      bus.bvalid  <= 1'b0;
      aw_held     <= 1'b0;
      w_held      <= 1'b0;
    end else begin
      if (bus.awvalid && bus.awready) begin
        bus.awready <= 1'b0;
        aw_held     <= 1'b1;
      end else if (bus.awvalid && !aw_held && !bus.bvalid) begin
        bus.awready <= 1'b1;
      end
      if (bus.wvalid && bus.wready) begin
        bus.wready <= 1'b0;
        w_held     <= 1'b1;
      end else if (bus.wvalid && !w_held && !bus.bvalid) begin
        bus.wready <= 1'b1;
      end
      if (write_now) begin
        aw_held    <= 1'b0;
        w_held     <= 1'b0;
        bus.bvalid <= 1'b1;
      end
      if (bus.bvalid && bus.bready) begin
        bus.bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (bus.awvalid && bus.awready) begin
      aw_addr <= bus.awaddr;
    end
    if (bus.wvalid && bus.wready) begin
      w_data <= bus.wdata;
      w_strb <= bus.wstrb;
    end
    if (write_now) begin
      bus.bresp <= in_window(aw_addr) ? resp_okay : resp_decerr;
    end
  end

endmodule

`default_nettype wire

/* logic/load_store_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module load_store_unit (
  input  wire                           clock,
  input  wire                           reset,
  input  wire                           ren,
  input  wire                           wen,
  input  wire                           suffix_b,
  input  wire                           suffix_h,
  input  wire                           sext,
  input  wire  [mem_pkg::data_width-1:0] addr,
  input  wire  [mem_pkg::data_width-1:0] wdata,
  output logic [mem_pkg::data_width-1:0] load_data,
  output logic                          read_done,
  output logic                          write_done,
  output logic                          busy,
  output logic                          access_fault,
  mem_bus_if.manager                    bus
);
  import mem_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_read_addr,
    st_read_data,
    st_write_addr,
    st_write_data,
    st_write_resp,
    st_finish
  } state_t;

  state_t state;

  logic [data_width-1:0] req_addr;
  logic [data_width-1:0] req_wdata;
  logic [strb_width-1:0] req_strb;
  logic                  req_byte;
  logic                  req_half;
  logic                  req_sext;
  logic                  accept;
  logic [strb_width-1:0] size_strb;
  logic [data_width-1:0] lane_data;
  logic [data_width-1:0] load_value;

  assign accept = (state == st_idle) && (ren || wen);
  assign busy = (state != st_idle);

  // --------------------------------------------------------------------------
  // request capture and store lane placement.
  // --------------------------------------------------------------------------
  assign size_strb = suffix_b ? 4'b0001 : (suffix_h ? 4'b0011 : 4'b1111);

  always_ff @(posedge clock) begin
    if (accept) begin
      req_addr  <= addr;
      req_wdata <= wdata << {addr[1:0], 3'b000};
      req_strb  <= size_strb << addr[1:0];
      req_byte  <= suffix_b;
      req_half  <= suffix_h;
      req_sext  <= sext;
    end
  end

  assign bus.araddr = req_addr;
  assign bus.awaddr = req_addr;
  assign bus.wdata  = req_wdata;
  assign bus.wstrb  = req_strb;

  // --------------------------------------------------------------------------
  // load lane selection and extension.
  // --------------------------------------------------------------------------
  assign lane_data = bus.rdata >> {req_addr[1:0], 3'b000};

  always_comb begin
    if (req_byte) begin
      load_value = {{24{req_sext & lane_data[7]}}, lane_data[7:0]};
    end else if (req_half) begin
      load_value = {{16{req_sext & lane_data[15]}}, lane_data[15:0]};
    end else begin
      load_value = lane_data;
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_read_data && bus.rvalid) begin
      load_data <= load_value;
    end
  end

  // --------------------------------------------------------------------------
  // transaction FSM.
  // --------------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= st_idle;
      bus.arvalid  <= 1'b0;
      bus.rready   <= 1'b0;
      bus.awvalid  <= 1'b0;
      bus.wvalid   <= 1'b0;
      bus.bready   <= 1'b0;
      read_done    <= 1'b0;
      write_done   <= 1'b0;
      access_fault <= 1'b0;
    end else begin
      read_done  <= 1'b0;
      write_done <= 1'b0;
      case (state)
        st_idle: begin
          // a store wins over a load raised in the same cycle.
          if (wen) begin
            bus.awvalid <= 1'b1;
            state       <= st_write_addr;
          end else if (ren) begin
            bus.arvalid <= 1'b1;
            state       <= st_read_addr;
          end
        end
        st_read_addr: begin
          if (bus.arready) begin
            bus.arvalid <= 1'b0;
            bus.rready  <= 1'b1;
            state       <= st_read_data;
          end
        end
        st_read_data: begin
          if (bus.rvalid) begin
            bus.rready   <= 1'b0;
            access_fault <= (bus.rresp != resp_okay);
            read_done    <= 1'b1;
            state        <= st_finish;
          end
        end
        st_write_addr: begin
          if (bus.awready) begin
            bus.awvalid <= 1'b0;
            bus.wvalid  <= 1'b1;
            state       <= st_write_data;
          end
        end
        st_write_data: begin
          if (bus.wready) begin
            bus.wvalid <= 1'b0;
            bus.bready <= 1'b1;
            state      <= st_write_resp;
          end
        end
        st_write_resp: begin
          if (bus.bvalid) begin
            bus.bready   <= 1'b0;
            access_fault <= (bus.bresp != resp_okay);
            write_done   <= 1'b1;
            state        <= st_finish;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/load_store_top.sv */
`timescale 1ns/100ps
`default_nettype none

module load_store_top (
  input  wire                            clock,
  input  wire                            reset,
  input  wire                            ren,
  input  wire                            wen,
  input  wire                            suffix_b,
  input  wire                            suffix_h,
  input  wire                            sext,
  input  wire  [mem_pkg::data_width-1:0] addr,
  input  wire  [mem_pkg::data_width-1:0] wdata,
  output logic [mem_pkg::data_width-1:0] load_data,
  output logic                           read_done,
  output logic                           write_done,
  output logic                           busy,
  output logic                           access_fault
);
  import mem_pkg::*;

  logic                        store_read_en;
  logic [word_index_width-1:0] store_read_index;
  logic [data_width-1:0]       store_read_data;
  logic                        store_write_en;
  logic [word_index_width-1:0] store_write_index;
  logic [data_width-1:0]       store_write_data;
  logic [strb_width-1:0]       store_write_strb;

  mem_bus_if bus_i ();

  // --------------------------------------------------------------------------
  // manager side.
  // --------------------------------------------------------------------------
  load_store_unit unit_i (
    .clock        (clock),
    .reset        (reset),
    .ren          (ren),
    .wen          (wen),
    .suffix_b     (suffix_b),
    .suffix_h     (suffix_h),
    .sext         (sext),
    .addr         (addr),
    .wdata        (wdata),
    .load_data    (load_data),
    .read_done    (read_done),
    .write_done   (write_done),
    .busy         (busy),
    .access_fault (access_fault),
    .bus          (bus_i.manager)
  );

  // --------------------------------------------------------------------------
  // memory side.
  // --------------------------------------------------------------------------
  mem_read_responder read_i (
    .clock            (clock),
    .reset            (reset),
    .bus              (bus_i.subordinate),
    .store_read_en    (store_read_en),
    .store_read_index (store_read_index),
    .store_read_data  (store_read_data)
  );

  mem_write_responder write_i (
    .clock             (clock),
    .reset             (reset),
    .bus               (bus_i.subordinate),
    .store_write_en    (store_write_en),
    .store_write_index (store_write_index),
    .store_write_data  (store_write_data),
    .store_write_strb  (store_write_strb)
  );

  data_store store_i (
    .clock       (clock),
    .read_en     (store_read_en),
    .read_index  (store_read_index),
    .write_en    (store_write_en),
    .write_index (store_write_index),
    .write_data  (store_write_data),
    .write_strb  (store_write_strb),
    .read_data   (store_read_data)
  );

endmodule

`default_nettype wire

/* verification/load_store_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module load_store_assertions (
  input wire                           clock,
  input wire                           reset,
  input wire                           ren,
  input wire                           wen,
  input wire                           suffix_b,
  input wire                           suffix_h,
  input wire                           sext,
  input wire [mem_pkg::data_width-1:0] addr,
  input wire [mem_pkg::data_width-1:0] wdata,
  input wire [mem_pkg::data_width-1:0] load_data,
  input wire                           read_done,
  input wire                           write_done,
  input wire                           busy,
  input wire                           access_fault
);
  import mem_pkg::*;

  localparam int shadow_size = mem_words * strb_width;
  localparam int offset_width = word_index_width + 2;
  localparam logic [data_width-1:0] window_bytes = data_width'(shadow_size);

  // shadow of every byte written through the top-level ports.
  logic [7:0] shadow_byte [shadow_size];
  bit         shadow_valid [shadow_size];

  logic                    started;
  logic                    pending;
  logic                    req_store;
  logic                    req_byte;
  logic                    req_half;
  logic                    req_sext;
  logic [data_width-1:0]   req_addr;
  logic [data_width-1:0]   req_wdata;
  logic [data_width-1:0]   req_offset;
  logic [offset_width-1:0] byte_offset;
  logic [data_width-1:0]   raw_word;
  logic [data_width-1:0]   expected_load;
  logic                    accept;
  logic                    req_inside;
  logic                    req_known;

  bit fail_idle;
  bit fail_load;
  bit fail_fault;
  bit fail_kind;
  bit fail_extra;
  bit fail_busy;
  bit any_failure;

  assign any_failure = fail_idle | fail_load | fail_fault | fail_kind | fail_extra | fail_busy;

  function automatic logic lane_used(input int lane, input logic is_byte, input logic is_half);
    if (is_byte) begin
      return lane == 0;
    end
    if (is_half) begin
      return lane < 2;
    end
    return 1'b1;
  endfunction

  // a request is taken only while no earlier request is outstanding.
  assign accept = !pending && (ren || wen);
  assign req_offset = req_addr - mem_base;
  assign byte_offset = req_offset[offset_width-1:0];
  assign req_inside = (req_addr >= mem_base) && (req_offset < window_bytes);

  always_ff @(posedge clock) begin
    if (reset) begin
      started <= 1'b0;
      pending <= 1'b0;
    end else if (accept) begin
      started <= 1'b1;
      pending <= 1'b1;
    end else if (read_done || write_done) begin
      pending <= 1'b0;
    end
    if (accept) begin
      req_store <= wen;
      req_byte  <= suffix_b;
      req_half  <= suffix_h;
      req_sext  <= sext;
      req_addr  <= addr;
      req_wdata <= wdata;
    end
  end

  // a store places the low bytes of wdata at the addressed byte and upward.
  always_ff @(posedge clock) begin
    if (!reset && write_done && req_inside) begin
      for (int lane = 0; lane < strb_width; lane++) begin
        if (lane_used(lane, req_byte, req_half)) begin
          shadow_byte[byte_offset + offset_width'(lane)] <= req_wdata[lane*8 +: 8];
          shadow_valid[byte_offset + offset_width'(lane)] <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    raw_word = '0;
    req_known = req_inside;
    for (int lane = 0; lane < strb_width; lane++) begin
      if (lane_used(lane, req_byte, req_half)) begin
        raw_word[lane*8 +: 8] = shadow_byte[byte_offset + offset_width'(lane)];
        if (!shadow_valid[byte_offset + offset_width'(lane)]) begin
          req_known = 1'b0;
        end
      end
    end
  end

  always_comb begin
    if (req_byte) begin
      expected_load = {{24{req_sext & raw_word[7]}}, raw_word[7:0]};
    end else if (req_half) begin
      expected_load = {{16{req_sext & raw_word[15]}}, raw_word[15:0]};
    end else begin
      expected_load = raw_word;
    end
  end

  // --------------------------------------------------------------------------
  // concurrent checks.
  // --------------------------------------------------------------------------
  idle_before_request: assert property (@(posedge clock) disable iff (reset)
      !started |-> !(read_done || write_done || busy || access_fault))
    else begin
      fail_idle = 1'b1;
      $error("Error at %0t: an output is active before the first request", $time);
    end

  busy_window: assert property (@(posedge clock) disable iff (reset)
      busy == pending)
    else begin
      fail_busy = 1'b1;
      $error("Error at %0t: busy %b, expected %b", $time, busy, pending);
    end

  load_value: assert property (@(posedge clock) disable iff (reset)
      read_done && req_known |-> load_data == expected_load)
    else begin
      fail_load = 1'b1;
      $error("Error at %0t: load_data %h, expected %h", $time, load_data, expected_load);
    end

  fault_flag: assert property (@(posedge clock) disable iff (reset)
      (read_done || write_done) |-> access_fault == !req_inside)
    else begin
      fail_fault = 1'b1;
      $error("Error at %0t: access_fault %b at address %h", $time, access_fault, req_addr);
    end

  done_kind: assert property (@(posedge clock) disable iff (reset)
      (read_done || write_done) |-> !(read_done && write_done) && (write_done == req_store))
    else begin
      fail_kind = 1'b1;
      $error("Error at %0t: done pulse does not match the accepted request", $time);
    end

  single_done: assert property (@(posedge clock) disable iff (reset)
      (read_done || write_done) |-> pending)
    else begin
      fail_extra = 1'b1;
      $error("Error at %0t: done pulse without an outstanding request", $time);
    end

endmodule

`default_nettype wire

/* verification/load_store_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module load_store_tb;
  import mem_pkg::*;

  localparam int clock_half = 2;
  localparam int clock_period = 2 * clock_half;
  localparam int reset_cycles = 8;
  localparam int region_words = 16;
  localparam int random_requests = 400;
  localparam int request_count = 2 * region_words + 24 + random_requests;
  localparam int cycle_bound = 40;
  localparam int seed = 16525;
  localparam logic [data_width-1:0] window_end = mem_base + data_width'(mem_words * strb_width);

  logic                  clock;
  logic                  reset;
  logic                  ren;
  logic                  wen;
  logic                  suffix_b;
  logic                  suffix_h;
  logic                  sext;
  logic [data_width-1:0] addr;
  logic [data_width-1:0] wdata;
  logic [data_width-1:0] load_data;
  logic                  read_done;
  logic                  write_done;
  logic                  busy;
  logic                  access_fault;
  int unsigned           seed_value;

  load_store_top dut_i (
    .clock        (clock),
    .reset        (reset),
    .ren          (ren),
    .wen          (wen),
    .suffix_b     (suffix_b),
    .suffix_h     (suffix_h),
    .sext         (sext),
    .addr         (addr),
    .wdata        (wdata),
    .load_data    (load_data),
    .read_done    (read_done),
    .write_done   (write_done),
    .busy         (busy),
    .access_fault (access_fault)
  );

  bind load_store_top load_store_assertions checks_i (
    .clock (clock), .reset (reset), .ren (ren), .wen (wen),
    .suffix_b (suffix_b), .suffix_h (suffix_h), .sext (sext),
    .addr (addr), .wdata (wdata), .load_data (load_data),
    .read_done (read_done), .write_done (write_done),
    .busy (busy), .access_fault (access_fault)
  );

  always #(clock_half) clock = ~clock;

  initial begin
    #((request_count * cycle_bound + reset_cycles + 32) * clock_period);
    $display("Errors found");
    $fatal(1, "watchdog expired at %0t before all requests completed", $time);
  end

  always @(posedge clock) begin
    if (dut_i.checks_i.any_failure) begin
      $display("Errors found");
      $fatal(1, "an assertion in the bound checker failed");
    end
  end

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  function automatic logic [data_width-1:0] region_addr(input int word, input int offset);
    return mem_base + data_width'(word * strb_width + offset);
  endfunction

  // size is 0 for a byte, 1 for a halfword and 2 for a word.
  task automatic run_request(input logic store, input logic load, input int size,
                             input logic extend, input logic [data_width-1:0] address,
                             input logic [data_width-1:0] data);
    while (busy) next_cycle();
    wen      = store;
    ren      = load;
    suffix_b = (size == 0);
    suffix_h = (size == 1);
    sext     = extend;
    addr     = address;
    wdata    = data;
    next_cycle();
    wen = 1'b0;
    ren = 1'b0;
    while (!(read_done || write_done)) next_cycle();
  endtask

  // requests raised while busy must be ignored by the unit.
  task automatic store_with_busy_requests(input logic [data_width-1:0] address);
    while (busy) next_cycle();
    wen      = 1'b1;
    suffix_b = 1'b0;
    suffix_h = 1'b0;
    addr     = address;
    wdata    = $urandom();
    next_cycle();
    ren = 1'b1;
    next_cycle();
    next_cycle();
    wen = 1'b0;
    ren = 1'b0;
    while (!(read_done || write_done)) next_cycle();
  endtask

  task automatic random_request();
    int size;
    int offset;
    int word;
    logic store;
    logic [data_width-1:0] address;
    size = $urandom_range(2, 0);
    word = $urandom_range(region_words - 1, 0);
    offset = (size == 0) ? $urandom_range(3, 0) : ((size == 1) ? 2 * $urandom_range(1, 0) : 0);
    store = ($urandom_range(1, 0) == 1);
    address = region_addr(word, offset);
    if ($urandom_range(7, 0) == 0) begin
      case ($urandom_range(2, 0))
        0: address = window_end + data_width'(word * strb_width + offset);
        1: address = mem_base - data_width'(64 - word * strb_width - offset);
        default: address = data_width'(32'h1000 + word * strb_width + offset);
      endcase
    end
    run_request(store, !store, size, ($urandom_range(1, 0) == 1), address, $urandom());
  endtask

  initial begin
    seed_value = $urandom(seed);
    clock = 1'b0;
    reset = 1'b1;
    ren = 1'b0;
    wen = 1'b0;
    suffix_b = 1'b0;
    suffix_h = 1'b0;
    sext = 1'b0;
    addr = '0;
    wdata = '0;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;
    repeat (4) next_cycle();

    // ------------------------------------------------------------------------
    // directed requests.
    // ------------------------------------------------------------------------
    for (int w = 0; w < region_words; w++) run_request(1, 0, 2, 0, region_addr(w, 0), $urandom());
    for (int w = 0; w < region_words; w++) run_request(0, 1, 2, 0, region_addr(w, 0), '0);

    // lanes hold positive and negative bytes and halfwords.
    run_request(1, 0, 2, 0, region_addr(1, 0), 32'h8081_7f01);
    for (int lane = 0; lane < 4; lane++) begin
      run_request(0, 1, 0, 0, region_addr(1, lane), '0);
      run_request(0, 1, 0, 1, region_addr(1, lane), '0);
    end
    for (int lane = 0; lane < 4; lane += 2) begin
      run_request(0, 1, 1, 0, region_addr(1, lane), '0);
      run_request(0, 1, 1, 1, region_addr(1, lane), '0);
    end

    run_request(1, 0, 0, 0, region_addr(2, 1), $urandom());
    run_request(1, 0, 1, 0, region_addr(2, 2), $urandom());
    run_request(0, 1, 2, 0, region_addr(2, 0), '0);

    // this store would land on word 3 if the window check were missing.
    run_request(1, 0, 2, 0, window_end + data_width'(12), $urandom());
    run_request(0, 1, 2, 0, region_addr(3, 0), '0);
    run_request(0, 1, 2, 0, mem_base - data_width'(4), '0);

    run_request(1, 1, 2, 0, region_addr(4, 0), $urandom());
    store_with_busy_requests(region_addr(5, 0));

    for (int i = 0; i < random_requests; i++) random_request();
    repeat (2) next_cycle();

    if (dut_i.checks_i.any_failure) begin
      $display("Errors found");
      $fatal(1, "an assertion in the bound checker failed");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* load_store.f */
logic/mem_pkg.sv
logic/mem_bus_if.sv
logic/data_store.sv
logic/mem_read_responder.sv
logic/mem_write_responder.sv
logic/load_store_unit.sv
logic/load_store_top.sv
verification/load_store_assertions.sv
verification/load_store_tb.sv

/* Makefile */
VERILATOR       ?= verilator
TOP             ?= load_store_tb
FILELIST        ?= load_store.f
BUILD_DIR       ?= obj_dir
LOG             ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
SIM_ARGS        ?= +verilator+error+limit+100
FAIL_MESSAGE    ?= Errors found
PASS_MESSAGE    ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MESSAGE)" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MESSAGE)" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
